// File: design/dcache_pkg.sv
// address fields, word type, cache geometry and controller states for the data cache
package dcache_pkg;

	// geometry
	localparam int SETS  = 8;
	localparam int IDX_W = 3;
	localparam int TAG_W = 26;

	// word address that receives the hit count at halt
	localparam logic [31:0] HIT_COUNT_ADDR = 32'h3100;

	typedef logic [31:0] word_t;

	typedef logic way_t;

	// byte address split for a two-word block
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic             blkoff;
		logic [1:0]       bytoff;
	} dcachef_t;

	typedef enum logic [3:0] {
		IDLE,
		LOOKUP,
		WB0,     // victim word 0 out
		WB1,     // victim word 1 out
		FILL0,
		FILL1,
		WALLOC,  // store word into victim way
		FLUSH0,
		FLUSH1,
		WCOUNT,
		HALTED
	} dcache_state_t;

endpackage

// File: design/cache_array_if.sv
// controller to line storage interface with ctrl and array modports
`timescale 1ns/1ps

interface cache_array_if;
	import dcache_pkg::*;

	// addressing
	word_t            lookup_addr;
	logic [IDX_W-1:0] flush_idx;
	way_t             flush_way;

	// write side, all applied at the next edge
	logic  wen;
	way_t  wway;
	logic  wsel;   // word within block
	word_t wdata;
	logic  set_tag;
	logic  set_valid;
	logic  clr_valid_all;
	logic  set_dirty;
	logic  clr_dirty;
	logic  touch;  // mark wway as most recently used

	// lookup results
	logic  hit;
	way_t  hit_way;
	word_t hit_word;

	// victim line of the lookup set
	way_t             vict_way;
	logic             vict_dirty;
	logic [TAG_W-1:0] vict_tag;
	word_t            vict_word0;
	word_t            vict_word1;

	// line under flush
	logic             fl_valid;
	logic             fl_dirty;
	logic [TAG_W-1:0] fl_tag;
	word_t            fl_word0;
	word_t            fl_word1;

	modport ctrl (
		output lookup_addr, flush_idx, flush_way,
		output wen, wway, wsel, wdata,
		output set_tag, set_valid, clr_valid_all, set_dirty, clr_dirty, touch,
		input  hit, hit_way, hit_word,
		input  vict_way, vict_dirty, vict_tag, vict_word0, vict_word1,
		input  fl_valid, fl_dirty, fl_tag, fl_word0, fl_word1
	);

	modport array (
		input  lookup_addr, flush_idx, flush_way,
		input  wen, wway, wsel, wdata,
		input  set_tag, set_valid, clr_valid_all, set_dirty, clr_dirty, touch,
		output hit, hit_way, hit_word,
		output vict_way, vict_dirty, vict_tag, vict_word0, vict_word1,
		output fl_valid, fl_dirty, fl_tag, fl_word0, fl_word1
	);

endinterface

// File: design/dcache_array.sv
// two-way line storage with tag compare, victim choice and flush read port
`timescale 1ns/1ps

module dcache_array (
	input logic CLK,
	input logic nRST,
	cache_array_if.array bus
);
	import dcache_pkg::*;

	// payload storage
	logic [TAG_W-1:0] tags  [2][SETS];
	word_t            words [2][SETS][2];

	// per line state indexed [way][set]
	logic [1:0][SETS-1:0] valid;
	logic [1:0][SETS-1:0] dirty;
	logic [SETS-1:0]      lru;   // way to evict next in each set

	dcachef_t a;
	logic     hit0, hit1;
	way_t     hway;
	way_t     vway;

	assign a = dcachef_t'(bus.lookup_addr);

	// tag compare
	assign hit0 = valid[0][a.idx] && (tags[0][a.idx] == a.tag);
	assign hit1 = valid[1][a.idx] && (tags[1][a.idx] == a.tag);
	assign hway = hit1 && !hit0;

	assign bus.hit      = hit0 || hit1;
	assign bus.hit_way  = hway;
	assign bus.hit_word = words[hway][a.idx][a.blkoff];

	// empty way first, otherwise least recently used
	always_comb begin
		if (!valid[0][a.idx])
			vway = 1'b0;
		else if (!valid[1][a.idx])
			vway = 1'b1;
		else
			vway = lru[a.idx];
	end

	assign bus.vict_way   = vway;
	assign bus.vict_dirty = valid[vway][a.idx] && dirty[vway][a.idx];
	assign bus.vict_tag   = tags[vway][a.idx];
	assign bus.vict_word0 = words[vway][a.idx][0];
	assign bus.vict_word1 = words[vway][a.idx][1];

	// second read port for the halt walk
	assign bus.fl_valid = valid[bus.flush_way][bus.flush_idx];
	assign bus.fl_dirty = dirty[bus.flush_way][bus.flush_idx];
	assign bus.fl_tag   = tags[bus.flush_way][bus.flush_idx];
	assign bus.fl_word0 = words[bus.flush_way][bus.flush_idx][0];
	assign bus.fl_word1 = words[bus.flush_way][bus.flush_idx][1];

	// line state
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end else begin
			if (bus.clr_valid_all)
				valid <= '0;
			else if (bus.set_valid)
				valid[bus.wway][a.idx] <= 1'b1;

			if (bus.set_dirty)
				dirty[bus.wway][a.idx] <= 1'b1;
			else if (bus.clr_dirty)
				dirty[bus.wway][a.idx] <= 1'b0;

			if (bus.touch)
				lru[a.idx] <= !bus.wway;
		end
	end

	// tags and data
	always_ff @(posedge CLK) begin
		if (bus.wen)
			words[bus.wway][a.idx][bus.wsel] <= bus.wdata;
		if (bus.set_tag)
			tags[bus.wway][a.idx] <= a.tag;
	end

endmodule

// File: design/dcache_ctrl.sv
// data cache controller: lookup, write-back, fill, flush and hit counter
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic              CLK,
	input  logic              nRST,
	// processor side
	input  logic              halt,
	input  logic              dmemREN,
	input  logic              dmemWEN,
	input  dcache_pkg::word_t dmemaddr,
	input  dcache_pkg::word_t dmemstore,
	output dcache_pkg::word_t dmemload,
	output logic              dhit,
	output logic              flushed,
	// memory side
	output logic              dREN,
	output logic              dWEN,
	output dcache_pkg::word_t daddr,
	output dcache_pkg::word_t dstore,
	input  dcache_pkg::word_t dload,
	input  logic              dwait,
	cache_array_if.ctrl       bus
);
	import dcache_pkg::*;

	dcache_state_t state, next_state;

	word_t            hitcount;
	logic             missed;     // memory touched since request arrived
	logic [IDX_W-1:0] fidx;
	way_t             fway;

	dcachef_t req;
	logic     req_valid;
	logic     fl_write;
	logic     flush_step;
	logic     flush_last;

	assign req       = dcachef_t'(dmemaddr);
	assign req_valid = dmemREN || dmemWEN;

	assign bus.lookup_addr = dmemaddr;
	assign bus.flush_idx   = fidx;
	assign bus.flush_way   = fway;

	assign fl_write   = bus.fl_valid && bus.fl_dirty;
	assign flush_last = fway && (fidx == IDX_W'(SETS - 1));
	assign flush_step = (state == FLUSH0 && !fl_write) || (state == FLUSH1 && !dwait);

	assign dhit     = (state == LOOKUP) && req_valid && bus.hit;
	assign dmemload = bus.hit_word;
	assign flushed  = (state == HALTED);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state    <= IDLE;
			hitcount <= '0;
			missed   <= 1'b0;
			fidx     <= '0;
			fway     <= 1'b0;
		end else begin
			state <= next_state;
			if (dhit && !missed)
				hitcount <= hitcount + 1;
			if (state == IDLE)
				missed <= 1'b0;
			else if (dREN || dWEN)
				missed <= 1'b1;
			if (flush_step) begin
				fidx <= fidx + 1'b1;
				if (fidx == IDX_W'(SETS - 1))
					fway <= !fway;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (halt)
					next_state = FLUSH0;
				else if (req_valid)
					next_state = LOOKUP;
			end
			LOOKUP: begin
				if (bus.hit || !req_valid)
					next_state = IDLE;
				else if (bus.vict_dirty)
					next_state = WB0;
				else if (dmemWEN)
					next_state = WALLOC;
				else
					next_state = FILL0;
			end
			WB0: if (!dwait) next_state = WB1;
			WB1: begin
				if (!dwait)
					next_state = dmemWEN ? WALLOC : FILL0;
			end
			WALLOC: next_state = req.blkoff ? FILL0 : FILL1;   // fetch the other word
			FILL0: begin
				if (!dwait)
					next_state = dmemWEN ? LOOKUP : FILL1;
			end
			FILL1: if (!dwait) next_state = LOOKUP;
			FLUSH0: begin
				if (!fl_write)
					next_state = flush_last ? WCOUNT : FLUSH0;   // clean line
				else if (!dwait)
					next_state = FLUSH1;
			end
			FLUSH1: begin
				if (!dwait)
					next_state = flush_last ? WCOUNT : FLUSH0;
			end
			WCOUNT: if (!dwait) next_state = HALTED;
			HALTED: next_state = HALTED;
			default: next_state = IDLE;
		endcase
	end

	always_comb begin
		dREN              = 1'b0;
		dWEN              = 1'b0;
		daddr             = '0;
		dstore            = '0;
		bus.wen           = 1'b0;
		bus.wway          = (state == LOOKUP) ? bus.hit_way : bus.vict_way;
		bus.wsel          = req.blkoff;
		bus.wdata         = dmemstore;
		bus.set_tag       = 1'b0;
		bus.set_valid     = 1'b0;
		bus.clr_valid_all = 1'b0;
		bus.set_dirty     = 1'b0;
		bus.clr_dirty     = 1'b0;
		bus.touch         = 1'b0;
		case (state)
			LOOKUP: begin
				if (dhit) begin
					bus.touch = 1'b1;
					if (dmemWEN) begin
						bus.wen       = 1'b1;
						bus.set_dirty = 1'b1;
					end
				end
			end
			WB0: begin
				dWEN   = 1'b1;
				daddr  = {bus.vict_tag, req.idx, 1'b0, 2'b00};
				dstore = bus.vict_word0;
			end
			WB1: begin
				dWEN   = 1'b1;
				daddr  = {bus.vict_tag, req.idx, 1'b1, 2'b00};
				dstore = bus.vict_word1;
			end
			WALLOC: begin
				bus.wen       = 1'b1;
				bus.set_dirty = 1'b1;
			end
			FILL0: begin
				dREN      = 1'b1;
				daddr     = {req.tag, req.idx, 1'b0, 2'b00};
				bus.wsel  = 1'b0;
				bus.wdata = dload;
				if (!dwait) begin
					bus.wen = 1'b1;
					if (dmemWEN) begin   // last word of a store allocate
						bus.set_tag   = 1'b1;
						bus.set_valid = 1'b1;
					end
				end
			end
			FILL1: begin
				dREN      = 1'b1;
				daddr     = {req.tag, req.idx, 1'b1, 2'b00};
				bus.wsel  = 1'b1;
				bus.wdata = dload;
				if (!dwait) begin
					bus.wen       = 1'b1;
					bus.set_tag   = 1'b1;
					bus.set_valid = 1'b1;
					bus.clr_dirty = !dmemWEN;
				end
			end
			FLUSH0: begin
				dWEN   = fl_write;
				daddr  = {bus.fl_tag, fidx, 1'b0, 2'b00};
				dstore = bus.fl_word0;
			end
			FLUSH1: begin
				dWEN   = 1'b1;
				daddr  = {bus.fl_tag, fidx, 1'b1, 2'b00};
				dstore = bus.fl_word1;
			end
			WCOUNT: begin
				dWEN              = 1'b1;
				daddr             = HIT_COUNT_ADDR;
				dstore            = hitcount;
				bus.clr_valid_all = !dwait;
			end
			default: ;
		endcase
	end

endmodule

// File: design/dcache.sv
// data cache top level with plain processor and memory ports
`timescale 1ns/1ps

module dcache (
	input  logic              CLK,
	input  logic              nRST,
	// processor side
	input  logic              halt,
	input  logic              dmemREN,
	input  logic              dmemWEN,
	input  dcache_pkg::word_t dmemaddr,
	input  dcache_pkg::word_t dmemstore,
	output dcache_pkg::word_t dmemload,
	output logic              dhit,
	output logic              flushed,
	// memory side
	output logic              dREN,
	output logic              dWEN,
	output dcache_pkg::word_t daddr,
	output dcache_pkg::word_t dstore,
	input  dcache_pkg::word_t dload,
	input  logic              dwait
);

	cache_array_if bus ();

	dcache_array i_array (
		.CLK  (CLK),
		.nRST (nRST),
		.bus  (bus.array)
	);

	dcache_ctrl i_ctrl (
		.CLK       (CLK),
		.nRST      (nRST),
		.halt      (halt),
		.dmemREN   (dmemREN),
		.dmemWEN   (dmemWEN),
		.dmemaddr  (dmemaddr),
		.dmemstore (dmemstore),
		.dmemload  (dmemload),
		.dhit      (dhit),
		.flushed   (flushed),
		.dREN      (dREN),
		.dWEN      (dWEN),
		.daddr     (daddr),
		.dstore    (dstore),
		.dload     (dload),
		.dwait     (dwait),
		.bus       (bus.ctrl)
	);

endmodule

// File: tests/dcache_sva.sv
// protocol assertions on the data cache ports
`timescale 1ns/1ps

module dcache_sva (
	input logic        CLK,
	input logic        nRST,
	input logic        dREN,
	input logic        dWEN,
	input logic [31:0] daddr,
	input logic        dhit,
	input logic        dmemREN,
	input logic        dmemWEN,
	input logic        flushed
);

	int fail_count = 0;   // polled by the testbench

	one_direction: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
		else begin
			$error("dREN and dWEN high together");
			fail_count++;
		end

	word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
			(dREN || dWEN) |-> (daddr[1:0] == 2'b00))
		else begin
			$error("daddr not word aligned during a memory access");
			fail_count++;
		end

	hit_needs_request: assert property (@(posedge CLK) disable iff (!nRST)
			dhit |-> (dmemREN || dmemWEN))
		else begin
			$error("dhit without a processor request");
			fail_count++;
		end

	flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
		else begin
			$error("flushed fell before reset");
			fail_count++;
		end

	// first edge out of reset
	quiet_after_reset: assert property (@(posedge CLK)
			$rose(nRST) |-> (!dREN && !dWEN && !dhit && !flushed))
		else begin
			$error("control outputs active right after reset");
			fail_count++;
		end

endmodule

// File: tests/tb_dcache.sv
// clock, reset, memory model, stimulus and checks for the data cache testbench
`timescale 1ns/1ps

module tb_dcache;
	import dcache_pkg::*;

	localparam int    MEM_WORDS  = 4096;
	localparam int    POOL_SIZE  = 40;
	localparam int    N_OPS      = 250;
	localparam int    WAIT_PCT   = 40;     // chance of a wait cycle per memory cycle
	localparam int    MAX_CYCLES = 20000;  // ~500 requests at up to ~30 cycles plus flush
	localparam word_t SEED       = 32'h7032_3f9c;
	localparam word_t EVICT_A    = 32'h2030;   // three tags on set 6
	localparam word_t EVICT_B    = 32'h2430;
	localparam word_t EVICT_C    = 32'h2830;

	logic  CLK;
	logic  nRST;
	logic  halt;
	logic  dmemREN;
	logic  dmemWEN;
	word_t dmemaddr;
	word_t dmemstore;
	word_t dmemload;
	logic  dhit;
	logic  flushed;
	logic  dREN;
	logic  dWEN;
	word_t daddr;
	word_t dstore;
	word_t dload;
	logic  dwait;

	word_t  model_mem [MEM_WORDS];
	word_t  ref_mem   [MEM_WORDS];
	logic   written   [MEM_WORDS];
	word_t  pool      [POOL_SIZE];
	word_t  hits_seen;
	integer seed      = SEED;
	integer wait_seed = SEED;   // own stream for the memory model
	int     cycle_count = 0;

	dcache i_dcache (
		.CLK       (CLK),
		.nRST      (nRST),
		.halt      (halt),
		.dmemREN   (dmemREN),
		.dmemWEN   (dmemWEN),
		.dmemaddr  (dmemaddr),
		.dmemstore (dmemstore),
		.dmemload  (dmemload),
		.dhit      (dhit),
		.flushed   (flushed),
		.dREN      (dREN),
		.dWEN      (dWEN),
		.daddr     (daddr),
		.dstore    (dstore),
		.dload     (dload),
		.dwait     (dwait)
	);

	bind dcache dcache_sva i_sva (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic int word_index(input word_t a);
		return {20'd0, a[13:2]};
	endfunction

	// initial memory contents from the full byte address
	function automatic word_t fill_word(input word_t a);
		return (a * 32'h9e37_79b9) ^ 32'h5bd1_e995;
	endfunction

	task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
		$display("[FAIL] %s: expected 0x%08h, actual 0x%08h", what, expected, actual);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// one processor request held until dhit
	task automatic access(input word_t addr, input logic write, input word_t data,
			input logic expect_hit);
		int    cycles;
		logic  used_mem;
		word_t expected;
		@(negedge CLK);
		dmemaddr  = addr;
		dmemstore = data;
		dmemREN   = !write;
		dmemWEN   = write;
		cycles    = 1;   // IDLE sampling cycle
		used_mem  = 1'b0;
		do begin
			@(negedge CLK);
			cycles++;
			if (dREN || dWEN)
				used_mem = 1'b1;
		end while (!dhit);
		expected = ref_mem[word_index(addr)];
		if (!used_mem)
			hits_seen = hits_seen + 1;
		if (expect_hit)
			assert (cycles == 2) else report_mismatch("hit latency", 2, word_t'(cycles));
		if (write) begin
			ref_mem[word_index(addr)] = data;
			written[word_index(addr)] = 1'b1;
		end else begin
			assert (dmemload == expected) else report_mismatch("read data", expected, dmemload);
		end
	endtask

	// memory model completing a word where dwait is low
	initial begin
		dwait = 1'b1;
		dload = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = fill_word(word_t'(i) << 2);
		forever begin
			@(negedge CLK);
			if (dREN || dWEN) begin
				dwait = ($unsigned($random(wait_seed)) % 100) < WAIT_PCT;
				if (!dwait && dREN)
					dload = model_mem[word_index(daddr)];
				if (!dwait && dWEN)
					model_mem[word_index(daddr)] = dstore;
			end else begin
				dwait = 1'b1;
				dload = '0;
			end
		end
	end

	always @(negedge CLK) begin
		cycle_count++;
		if (i_dcache.i_sva.fail_count != 0) begin
			$display("a protocol assertion on the DUT ports failed");
			$display("Test FAILED");
			$fatal(1);
		end else if (cycle_count >= MAX_CYCLES) begin
			$display("timeout after %0d cycles without finishing", cycle_count);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	initial begin
		word_t r;
		word_t addr;
		int    sel;
		nRST      = 1'b0;
		halt      = 1'b0;
		dmemREN   = 1'b0;
		dmemWEN   = 1'b0;
		dmemaddr  = '0;
		dmemstore = '0;
		hits_seen = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = fill_word(word_t'(i) << 2);
			written[i] = 1'b0;
		end
		// five tags per set over both block words
		for (int i = 0; i < POOL_SIZE; i++)
			pool[i] = 32'h1000 + word_t'(i % 5) * 32'h40 + word_t'(i / 5) * 32'h8
				+ word_t'(i % 2) * 32'h4;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;

		access(EVICT_A, 1'b1, 32'haaaa_0001, 1'b0);
		access(EVICT_B, 1'b1, 32'hbbbb_0002, 1'b0);
		access(EVICT_C, 1'b1, 32'hcccc_0003, 1'b0);
		assert (model_mem[word_index(EVICT_A)] == ref_mem[word_index(EVICT_A)])
			else report_mismatch("dirty eviction", ref_mem[word_index(EVICT_A)],
				model_mem[word_index(EVICT_A)]);

		for (int n = 0; n < N_OPS; n++) begin
			r    = $random(seed);
			sel  = $unsigned($random(seed)) % POOL_SIZE;
			addr = pool[sel];
			access(addr, r[0], $random(seed), 1'b0);
			if (r[1])   // same block again
				access(addr ^ {29'd0, r[2], 2'b00}, r[3], $random(seed), 1'b1);
		end

		@(negedge CLK);
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		halt    = 1'b1;
		do begin
			@(negedge CLK);
		end while (!flushed);
		for (int i = 0; i < MEM_WORDS; i++)
			if (written[i])
				assert (model_mem[i] == ref_mem[i])
					else report_mismatch("memory after flush", ref_mem[i], model_mem[i]);
		assert (model_mem[word_index(HIT_COUNT_ADDR)] == hits_seen)
			else report_mismatch("hit count", hits_seen, model_mem[word_index(HIT_COUNT_ADDR)]);

		if (i_dcache.i_sva.fail_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("a protocol assertion on the DUT ports failed");
			$display("Test FAILED");
			$fatal(1);
		end
	end

endmodule

// File: dcache.f
design/dcache_pkg.sv
design/cache_array_if.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache.sv
tests/dcache_sva.sv
tests/tb_dcache.sv

// File: Makefile
TOP = tb_dcache
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dcache.f -Mdir obj_dir

run: build
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test OK" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f dcache.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
